//--- filelist.f
rtl/cache_pkg.sv
rtl/tag_store.sv
rtl/meta_store.sv
rtl/way_select.sv
rtl/data_store.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
tb/tb_mem_model.sv
tb/tb_cache_top.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := tb_cache_top
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Errors found
PASS_MSG  := No errors

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tb_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top
    import cache_pkg::*;
();

    localparam int SEED        = 93;
    localparam int CLK_PERIOD  = 10;
    localparam int NUM_XFERS   = 400;
    localparam int FLUSH_XFERS = NUM_SETS * NUM_WAYS;
    localparam int XFER_CYCLES = 40;
    localparam int WATCHDOG_NS = (NUM_XFERS + FLUSH_XFERS + 8) * XFER_CYCLES * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       psel;
    logic       penable;
    logic       pwrite;
    addr_t      paddr;
    word_t      pwdata;
    word_t      prdata;
    logic       pready;
    logic       pslverr;
    logic       mem_req;
    logic       mem_we;
    line_addr_t mem_addr;
    line_t      mem_wdata;
    logic       mem_ack;
    line_t      mem_rdata;
    logic       lookup_done;
    logic       lookup_hit;

    // reference cache and memory.
    tag_t  m_tag   [NUM_SETS][NUM_WAYS];
    logic  m_valid [NUM_SETS][NUM_WAYS];
    logic  m_dirty [NUM_SETS][NUM_WAYS];
    age_t  m_age   [NUM_SETS][NUM_WAYS];
    line_t m_line  [NUM_SETS][NUM_WAYS];
    line_t ref_mem [1024];

    logic       exp_hit;
    logic       exp_err;
    word_t      exp_rdata;
    logic       exp_evict;
    line_addr_t exp_evict_addr;
    line_t      exp_evict_line;
    line_addr_t exp_fill_addr;
    int         exp_fills;
    int         exp_lookups;
    int         lookups_seen;
    int         fills_seen;
    int         evicts_seen;
    string      test_name = "reset";
    int         errors = 0;
    int         seed = SEED;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cache_top uut (
        .clk(clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .lookup_done(lookup_done), .lookup_hit(lookup_hit)
    );

    tb_mem_model #(.SEED(SEED)) mem_i (
        .clk(clk), .arst_n(arst_n),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    task automatic fail_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) fail_run($sformatf("[ERROR] %s %s: expected %h, actual %h",
                                            test_name, what, exp, act));
    endtask

    task automatic check_hit(input string what, input logic exp, input logic act);
        if (act !== exp) fail_run($sformatf("[ERROR] %s %s: expected %b, actual %b",
                                            test_name, what, exp, act));
    endtask

    task automatic check_err(input string what, input logic exp, input logic act);
        if (act !== exp) fail_run($sformatf("[ERROR] %s %s: expected %b, actual %b",
                                            test_name, what, exp, act));
    endtask

    task automatic check_line(input string what, input line_t exp, input line_t act);
        if (act !== exp) fail_run($sformatf("[ERROR] %s %s: expected %h, actual %h",
                                            test_name, what, exp, act));
    endtask

    task automatic check_addr(input string what, input line_addr_t exp, input line_addr_t act);
        if (act !== exp) fail_run($sformatf("[ERROR] %s %s: expected %h, actual %h",
                                            test_name, what, exp, act));
    endtask

    function automatic line_t pattern_line(input line_addr_t a);
        line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*WORD_W +: WORD_W] = {2'b10, a, 2'(w), ~a, 8'h3c};
        end
        return l;
    endfunction

    // lowest invalid way, else the least recently used one.
    function automatic int pick_victim(input set_idx_t s);
        int v;
        v = -1;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!m_valid[s][w]) v = w;
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (v < 0 && m_age[s][w] == age_t'(NUM_WAYS - 1)) v = w;
        end
        return (v < 0) ? 0 : v;
    endfunction

    task automatic model_access(input logic write, input addr_t addr, input word_t wdata);
        tag_t       t;
        set_idx_t   s;
        int         wo;
        int         way;
        int         old_age;
        line_addr_t victim_addr;
        t   = addr[13:6];
        s   = addr[5:4];
        wo  = int'(addr[3:2]) * WORD_W;
        way = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) way = w;
        end
        exp_hit     = (way >= 0);
        exp_lookups = exp_hit ? 1 : 2;   // a miss looks up again after the fill.
        exp_fills   = exp_hit ? 0 : 1;
        if (exp_hit) begin
            old_age = int'(m_age[s][way]);
        end else begin
            way         = pick_victim(s);
            victim_addr = {m_tag[s][way], s};
            if (m_valid[s][way] && m_dirty[s][way]) begin
                exp_evict            = 1'b1;
                exp_evict_addr       = victim_addr;
                exp_evict_line       = m_line[s][way];
                ref_mem[victim_addr] = m_line[s][way];
            end
            exp_fill_addr  = {t, s};
            m_line[s][way] = ref_mem[{t, s}];
            m_tag[s][way]  = t;
            m_valid[s][way] = 1'b1;
            m_dirty[s][way] = 1'b0;
            old_age = NUM_WAYS - 1;   // new line enters as the oldest.
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (w == way) m_age[s][w] = '0;
            else if (int'(m_age[s][w]) < old_age) m_age[s][w] = m_age[s][w] + age_t'(1);
        end
        if (write) begin
            m_line[s][way][wo +: WORD_W] = wdata;
            m_dirty[s][way] = 1'b1;
        end
        exp_rdata = m_line[s][way][wo +: WORD_W];
    endtask

    task automatic do_transfer(input logic write, input addr_t addr, input word_t wdata);
        int n;
        exp_err     = |addr[1:0];
        exp_hit     = 1'b0;
        exp_evict   = 1'b0;
        exp_fills   = 0;
        exp_lookups = 0;
        if (!exp_err) model_access(write, addr, wdata);
        lookups_seen = 0;
        fills_seen   = 0;
        evicts_seen  = 0;
        n = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        do begin
            @(negedge clk);
            n++;
            if (n > XFER_CYCLES) fail_run($sformatf("%s: no pready within %0d cycles",
                                                    test_name, XFER_CYCLES));
        end while (!pready);
        check_err("slave error", exp_err, pslverr);
        if (!write && !exp_err) check_word("read data", exp_rdata, prdata);
        psel    = 1'b0;
        penable = 1'b0;
        if (lookups_seen != exp_lookups || fills_seen != exp_fills
                || evicts_seen != int'(exp_evict)) begin
            fail_run($sformatf("%s: lookup or memory traffic does not fit the access", test_name));
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && lookup_done) begin
            lookups_seen++;
            if (exp_err) fail_run("lookup started for a misaligned access");
            check_hit("lookup hit", (lookups_seen == 1) ? exp_hit : 1'b1, lookup_hit);
        end
        if (arst_n && mem_req && exp_fills == 0) begin
            fail_run("memory request in a transfer that needs no line");
        end
        if (arst_n && mem_req && mem_ack) begin
            if (mem_we) begin
                evicts_seen++;
                if (!exp_evict) fail_run("eviction write for a clean or invalid victim");
                check_addr("eviction address", exp_evict_addr, mem_addr);
                check_line("eviction data", exp_evict_line, mem_wdata);
            end else begin
                fills_seen++;
                check_addr("fill address", exp_fill_addr, mem_addr);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run($sformatf("watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS));
    end

    initial begin
        word_t r;
        word_t wdata;
        addr_t addr;
        tag_t  tag_sel;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w]   = '0;
                m_line[s][w]  = '0;
            end
        end
        for (int a = 0; a < 1024; a++) ref_mem[a] = pattern_line(line_addr_t'(a));
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            if (pready || pslverr || mem_req || lookup_done || lookup_hit) begin
                fail_run("outputs not idle after reset");
            end
        end

        // six tags per set against four ways keeps the sets conflicting.
        for (int i = 0; i < NUM_XFERS; i++) begin
            r       = $random(seed);
            wdata   = $random(seed);
            tag_sel = tag_t'(r[20:13] % 8'd6);
            addr    = {tag_t'(8'h10 + 8'h11 * tag_sel), r[2:1], r[4:3], 2'b00};
            if (r[8:5] == 4'd0) addr[1:0] = (r[10:9] == 2'b00) ? 2'b01 : r[10:9];
            test_name = $sformatf("transfer %0d", i);
            do_transfer(r[0], addr, wdata);
        end

        // reads of unused tags push every dirty line out.
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int k = 0; k < NUM_WAYS; k++) begin
                test_name = $sformatf("flush set %0d read %0d", s, k);
                do_transfer(1'b0, {tag_t'(8'hf0 + k), set_idx_t'(s), 4'b0000}, '0);
            end
        end

        test_name = "memory compare";
        for (int a = 0; a < 1024; a++) begin
            check_line($sformatf("line %03h", a), ref_mem[a], mem_i.mem[a]);
        end

        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
    import cache_pkg::*;
#(
    parameter int SEED = 93
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       mem_req,
    input  logic       mem_we,
    input  line_addr_t mem_addr,
    input  line_t      mem_wdata,
    output logic       mem_ack,
    output line_t      mem_rdata
);

    line_t      mem [1024];
    logic       pending;
    logic [2:0] wait_cnt;
    int         seed = SEED;

    // every word carries its own line address and word number.
    function automatic line_t pattern_line(input line_addr_t a);
        line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*WORD_W +: WORD_W] = {2'b10, a, 2'(w), ~a, 8'h3c};
        end
        return l;
    endfunction

    initial begin
        for (int a = 0; a < 1024; a++) begin
            mem[a] = pattern_line(line_addr_t'(a));
        end
    end

    assign mem_rdata = mem[mem_addr];   // valid while the fill request is held.

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_ack  <= 1'b0;
            pending  <= 1'b0;
            wait_cnt <= '0;
        end else if (mem_ack) begin
            if (mem_we) mem[mem_addr] = mem_wdata;   // eviction lands with the ack.
            mem_ack <= 1'b0;
            pending <= 1'b0;
        end else if (mem_req && !pending) begin
            pending  <= 1'b1;
            wait_cnt <= 3'($random(seed));   // 0 to 7 cycles of back-pressure.
        end else if (pending) begin
            if (wait_cnt == 3'd0) mem_ack <= 1'b1;
            else wait_cnt <= wait_cnt - 3'd1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top
    import cache_pkg::*;
#(
    parameter int MEM_TIMEOUT = 64
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  addr_t      paddr,
    input  word_t      pwdata,
    output word_t      prdata,
    output logic       pready,
    output logic       pslverr,
    output logic       mem_req,
    output logic       mem_we,
    output line_addr_t mem_addr,
    output line_t      mem_wdata,
    input  logic       mem_ack,
    input  line_t      mem_rdata,
    output logic       lookup_done,
    output logic       lookup_hit
);

    set_idx_t            set_idx;
    tag_t                tag;
    word_idx_t           word_idx;
    way_t                access_way;
    logic                tag_we;
    logic                data_word_we;
    logic                data_line_we;
    line_t               fill_line;
    logic                meta_touch;
    logic                meta_fill;
    logic                meta_dirty_set;
    way_vec_t            hits;
    tag_t                victim_tag;
    way_vec_t            valid;
    way_vec_t            dirty;
    age_t [NUM_WAYS-1:0] ages;
    logic                hit;
    way_t                hit_way;
    way_t                victim_way;
    logic                victim_dirty;
    line_t               line_out;
    word_t               word_out;

    cache_ctrl #(
        .MEM_TIMEOUT(MEM_TIMEOUT)
    ) u_ctrl (
        .clk(clk),
        .arst_n(arst_n),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .hit(hit),
        .hit_way(hit_way),
        .victim_way(victim_way),
        .victim_dirty(victim_dirty),
        .victim_tag(victim_tag),
        .line_out(line_out),
        .word_out(word_out),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .set_idx(set_idx),
        .tag(tag),
        .word_idx(word_idx),
        .access_way(access_way),
        .tag_we(tag_we),
        .data_word_we(data_word_we),
        .data_line_we(data_line_we),
        .fill_line(fill_line),
        .meta_touch(meta_touch),
        .meta_fill(meta_fill),
        .meta_dirty_set(meta_dirty_set),
        .mem_req(mem_req),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .lookup_done(lookup_done),
        .lookup_hit(lookup_hit)
    );

    tag_store u_tags (
        .clk(clk),
        .arst_n(arst_n),
        .set_idx(set_idx),
        .tag(tag),
        .tag_we(tag_we),
        .access_way(access_way),
        .hits(hits),
        .victim_tag(victim_tag)
    );

    meta_store u_meta (
        .clk(clk),
        .arst_n(arst_n),
        .set_idx(set_idx),
        .access_way(access_way),
        .meta_touch(meta_touch),
        .meta_fill(meta_fill),
        .meta_dirty_set(meta_dirty_set),
        .valid(valid),
        .dirty(dirty),
        .ages(ages)
    );

    way_select u_sel (
        .hits(hits),
        .valid(valid),
        .dirty(dirty),
        .ages(ages),
        .hit(hit),
        .hit_way(hit_way),
        .victim_way(victim_way),
        .victim_dirty(victim_dirty)
    );

    data_store u_data (
        .clk(clk),
        .set_idx(set_idx),
        .access_way(access_way),
        .word_idx(word_idx),
        .data_word_we(data_word_we),
        .pwdata(pwdata),
        .data_line_we(data_line_we),
        .fill_line(fill_line),
        .line_out(line_out),
        .word_out(word_out)
    );

endmodule

`default_nettype wire

//--- rtl/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
    import cache_pkg::*;
#(
    parameter int MEM_TIMEOUT = 64
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  addr_t      paddr,
    input  word_t      pwdata,
    input  logic       hit,
    input  way_t       hit_way,
    input  way_t       victim_way,
    input  logic       victim_dirty,
    input  tag_t       victim_tag,
    input  line_t      line_out,
    input  word_t      word_out,
    input  logic       mem_ack,
    input  line_t      mem_rdata,
    output word_t      prdata,
    output logic       pready,
    output logic       pslverr,
    output set_idx_t   set_idx,
    output tag_t       tag,
    output word_idx_t  word_idx,
    output way_t       access_way,
    output logic       tag_we,
    output logic       data_word_we,
    output logic       data_line_we,
    output line_t      fill_line,
    output logic       meta_touch,
    output logic       meta_fill,
    output logic       meta_dirty_set,
    output logic       mem_req,
    output logic       mem_we,
    output line_addr_t mem_addr,
    output line_t      mem_wdata,
    output logic       lookup_done,
    output logic       lookup_hit
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    way_t        way_q;   // victim way, held through evict and fill.
    logic        err_q;
    word_t       rdata_q;
    logic        access;
    logic        misaligned;

    assign access     = psel && penable;
    assign misaligned = |paddr[1:0];

    assign tag      = paddr[13:6];
    assign set_idx  = paddr[5:4];
    assign word_idx = paddr[3:2];

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (access) state_nxt = misaligned ? RESPOND : LOOKUP;
            end
            LOOKUP: begin
                if (hit) state_nxt = RESPOND;
                else if (victim_dirty) state_nxt = EVICT;
                else state_nxt = FILL;
            end
            EVICT: begin
                if (mem_ack) state_nxt = FILL;
            end
            FILL: begin
                if (mem_ack) state_nxt = LOOKUP;   // re-lookup now hits.
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            err_q <= 1'b0;
            way_q <= '0;
        end else begin
            state <= state_nxt;
            if (state == IDLE && access) err_q <= misaligned;
            if (state == LOOKUP && !hit) way_q <= victim_way;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_hit) rdata_q <= word_out;
    end

    // during lookup the way comes straight from the selector.
    assign access_way = (state == LOOKUP) ? (hit ? hit_way : victim_way) : way_q;

    always_comb begin
        fill_line = mem_rdata;
        if (pwrite) fill_line[word_idx*WORD_W +: WORD_W] = pwdata;   // merge write word.
    end

    assign lookup_done    = (state == LOOKUP);
    assign lookup_hit     = lookup_done && hit;
    assign meta_touch     = lookup_hit;
    assign data_word_we   = lookup_hit && pwrite;
    assign meta_dirty_set = data_word_we;

    assign tag_we       = (state == FILL) && mem_ack;
    assign data_line_we = tag_we;
    assign meta_fill    = tag_we;

    assign mem_req   = (state == EVICT) || (state == FILL);
    assign mem_we    = (state == EVICT);
    assign mem_addr  = mem_we ? {victim_tag, set_idx} : {tag, set_idx};
    assign mem_wdata = line_out;   // victim line, read at way_q.

    assign pready  = (state == RESPOND);
    assign pslverr = pready && err_q;
    assign prdata  = rdata_q;

    a_mem_stable: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req && !mem_ack |=> mem_req && $stable(mem_we) && $stable(mem_addr)
                                && $stable(mem_wdata));

    a_mem_timeout: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req |-> ##[0:MEM_TIMEOUT] mem_ack);

endmodule

`default_nettype wire

//--- rtl/data_store.sv
`timescale 1ns/1ps
`default_nettype none

module data_store
    import cache_pkg::*;
(
    input  logic      clk,
    input  set_idx_t  set_idx,
    input  way_t      access_way,
    input  word_idx_t word_idx,
    input  logic      data_word_we,
    input  word_t     pwdata,
    input  logic      data_line_we,
    input  line_t     fill_line,
    output line_t     line_out,
    output word_t     word_out
);

    line_t lines [NUM_SETS][NUM_WAYS];

    always_ff @(posedge clk) begin
        if (data_line_we) begin
            lines[set_idx][access_way] <= fill_line;
        end else if (data_word_we) begin
            lines[set_idx][access_way][word_idx*WORD_W +: WORD_W] <= pwdata;
        end
    end

    // read side is combinational, used by lookup and eviction.
    assign line_out = lines[set_idx][access_way];
    assign word_out = line_out[word_idx*WORD_W +: WORD_W];

endmodule

`default_nettype wire

//--- rtl/way_select.sv
`timescale 1ns/1ps
`default_nettype none

module way_select
    import cache_pkg::*;
(
    input  way_vec_t            hits,
    input  way_vec_t            valid,
    input  way_vec_t            dirty,
    input  age_t [NUM_WAYS-1:0] ages,
    output logic                hit,
    output way_t                hit_way,
    output way_t                victim_way,
    output logic                victim_dirty
);

    way_vec_t hits_v;
    logic     found_inv;

    assign hits_v = hits & valid;
    assign hit    = |hits_v;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hits_v[w]) hit_way = way_t'(w);
        end
    end

    // lowest invalid way first.
    always_comb begin
        victim_way = '0;
        found_inv  = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!valid[w] && !found_inv) begin
                victim_way = way_t'(w);
                found_inv  = 1'b1;
            end
        end
        if (!found_inv) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (ages[w] == age_t'(NUM_WAYS - 1)) victim_way = way_t'(w);   // lru way.
            end
        end
    end

    assign victim_dirty = valid[victim_way] && dirty[victim_way];

    always_comb begin
        a_one_hit: assert final ($onehot0(hits_v));
    end

endmodule

`default_nettype wire

//--- rtl/meta_store.sv
`timescale 1ns/1ps
`default_nettype none

module meta_store
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  set_idx_t            set_idx,
    input  way_t                access_way,
    input  logic                meta_touch,
    input  logic                meta_fill,
    input  logic                meta_dirty_set,
    output way_vec_t            valid,
    output way_vec_t            dirty,
    output age_t [NUM_WAYS-1:0] ages
);

    way_vec_t            valid_q [NUM_SETS];
    way_vec_t            dirty_q [NUM_SETS];
    age_t [NUM_WAYS-1:0] age_q   [NUM_SETS];
    age_t                old_age;

    function automatic logic ages_distinct(input age_t [NUM_WAYS-1:0] a);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < NUM_WAYS; i++) begin
            for (int j = i + 1; j < NUM_WAYS; j++) begin
                if (a[i] == a[j]) ok = 1'b0;
            end
        end
        return ok;
    endfunction

    assign old_age = age_q[set_idx][access_way];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                age_q[s]   <= '0;
            end
        end else if (meta_fill) begin
            valid_q[set_idx][access_way] <= 1'b1;
            dirty_q[set_idx][access_way] <= 1'b0;
            // a new line starts oldest, so the touch that follows ages every other way.
            age_q[set_idx][access_way] <= age_t'(NUM_WAYS - 1);
        end else if (meta_touch) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (w == int'(access_way)) begin
                    age_q[set_idx][w] <= '0;
                end else if (age_q[set_idx][w] < old_age) begin
                    age_q[set_idx][w] <= age_q[set_idx][w] + age_t'(1);
                end
            end
            if (meta_dirty_set) dirty_q[set_idx][access_way] <= 1'b1;   // write hit.
        end
    end

    assign valid = valid_q[set_idx];
    assign dirty = dirty_q[set_idx];
    assign ages  = age_q[set_idx];

    for (genvar s = 0; s < NUM_SETS; s++) begin : g_age_chk
        a_ages_distinct: assert property (@(posedge clk) disable iff (!arst_n)
            &valid_q[s] |-> ages_distinct(age_q[s]));
    end

endmodule

`default_nettype wire

//--- rtl/tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  set_idx_t set_idx,
    input  tag_t     tag,
    input  logic     tag_we,
    input  way_t     access_way,
    output way_vec_t hits,
    output tag_t     victim_tag
);

    tag_t tags [NUM_SETS][NUM_WAYS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    tags[s][w] <= '0;
                end
            end
        end else if (tag_we) begin
            tags[set_idx][access_way] <= tag;
        end
    end

    // compare all ways of the set, valid masking happens later.
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hits[w] = (tags[set_idx][w] == tag);
        end
    end

    assign victim_tag = tags[set_idx][access_way];

endmodule

`default_nettype wire

//--- rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int ADDR_W         = 14;
    localparam int TAG_W          = 8;
    localparam int SET_W          = 2;
    localparam int WORD_IDX_W     = 2;
    localparam int WAY_W          = 2;
    localparam int AGE_W          = 2;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int NUM_SETS       = 4;
    localparam int NUM_WAYS       = 4;

    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [TAG_W-1:0]       tag_t;
    typedef logic [SET_W-1:0]       set_idx_t;
    typedef logic [WORD_IDX_W-1:0]  word_idx_t;
    typedef logic [WAY_W-1:0]       way_t;
    typedef logic [NUM_WAYS-1:0]    way_vec_t;
    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [LINE_W-1:0]      line_t;    // word 0 in the low bits.
    typedef logic [AGE_W-1:0]       age_t;     // 0 is most recently used.
    typedef logic [TAG_W+SET_W-1:0] line_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        EVICT,
        FILL,
        RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire
